/* dcache_params.svh */
// fixed geometry, the field widths below must add up to DC_ADDR_W
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address split
`define DC_ADDR_W   32
`define DC_TAG_W    22
`define DC_INDEX_W  6
`define DC_OFFSET_W 4

// beat and word width
`define DC_DATA_W   64

// placement
`define DC_WAYS     2
`define DC_WAY_W    1
`define DC_SETS     64

// two beats per 16-byte line
`define DC_BEATS    2
`define DC_BEAT_W   1

`endif

/* dcache_pkg.sv */
// types only, built on the fixed widths in the params header
`include "dcache_params.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0]   addr_t;   // memory channel address
  typedef logic [`DC_DATA_W-1:0]   beat_t;   // one memory beat, one cpu word
  typedef logic [`DC_DATA_W/8-1:0] strb_t;

  typedef struct packed {
    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_OFFSET_W-1:0] offset;
  } addr_fields_t;

  typedef logic [`DC_BEATS-1:0][`DC_DATA_W-1:0] line_t;  // beat 0 is the low word

  typedef struct packed {
    logic         write;
    addr_fields_t addr;
    beat_t        wdata;
    strb_t        strb;
  } cpu_req_t;

  typedef struct packed {
    logic  write;
    beat_t rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic                   en;
    logic [`DC_WAY_W-1:0]   way;
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_TAG_W-1:0]   tag;
    logic                   valid;
    logic                   dirty;
  } tag_upd_t;

  typedef struct packed {
    logic                   en;
    logic [`DC_WAY_W-1:0]   way;
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_BEAT_W-1:0]  beat;
    beat_t                  data;
    strb_t                  strb;
  } data_wr_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_resp,
    st_wb_addr,
    st_wb_data,
    st_wb_resp,
    st_fill_addr,
    st_fill_data
  } dc_state_e;

endpackage

/* dcache_tag_store.sv */
// two ways only; lookup is combinational, updates land on the next edge
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_tag_store (
  input  logic                     clk,
  input  logic                     rst,
  input  dcache_pkg::addr_fields_t lookup_i,
  input  logic                     victim_way_i,
  input  dcache_pkg::tag_upd_t     upd_i,
  output logic                     hit_o,
  output logic                     hit_way_o,
  output logic                     victim_dirty_o,
  output logic [`DC_TAG_W-1:0]     victim_tag_o
);

  logic [`DC_TAG_W-1:0]                tags [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]   valid_q;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]   dirty_q;
  logic [`DC_WAYS-1:0]                 way_hit;

  // flag bits, cleared so every line starts invalid
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (upd_i.en) begin
      valid_q[upd_i.way][upd_i.index] <= upd_i.valid;
      dirty_q[upd_i.way][upd_i.index] <= upd_i.dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_i.en) begin
      tags[upd_i.way][upd_i.index] <= upd_i.tag;
    end
  end

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_cmp
    assign way_hit[w] = valid_q[w][lookup_i.index] &&
                        (tags[w][lookup_i.index] == lookup_i.tag);
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];  // one-hot to index, two ways

  // victim info for the same set
  assign victim_dirty_o = valid_q[victim_way_i][lookup_i.index] &&
                          dirty_q[victim_way_i][lookup_i.index];
  assign victim_tag_o   = tags[victim_way_i][lookup_i.index];

  // a fill must never place a tag that is already present in the other way
  a_one_hit_way : assert property (@(posedge clk) disable iff (rst)
    !(&way_hit));

endmodule

/* dcache_data_store.sv */
// behavioral line storage, one cycle read latency, read returns pre-write data
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_data_store (
  input  logic                                clk,
  input  logic [`DC_INDEX_W-1:0]              rd_index_i,
  input  dcache_pkg::data_wr_t                wr_i,
  output dcache_pkg::line_t [`DC_WAYS-1:0]    lines_o
);
  import dcache_pkg::*;

  line_t mem_q [`DC_WAYS][`DC_SETS];

  // one beat per write, byte lanes under strobe
  always_ff @(posedge clk) begin
    if (wr_i.en) begin
      for (int b = 0; b < `DC_DATA_W/8; b++) begin
        if (wr_i.strb[b]) begin
          mem_q[wr_i.way][wr_i.index][wr_i.beat][8*b +: 8] <= wr_i.data[8*b +: 8];
        end
      end
    end
  end

  // both ways read every cycle
  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      lines_o[w] <= mem_q[w][rd_index_i];
    end
  end

  // controller only writes once it holds a known request or fill beat
  a_wr_index_known : assert property (@(posedge clk)
    wr_i.en |-> !$isunknown({wr_i.way, wr_i.index, wr_i.beat}));

endmodule

/* dcache_ctrl.sv */
// blocking, one access in flight; memory must return exactly two beats per fill
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  dcache_pkg::cpu_req_t             req_i,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output dcache_pkg::cpu_rsp_t             rsp_o,
  output logic                             mem_ar_valid_o,
  input  logic                             mem_ar_ready_i,
  output dcache_pkg::addr_t                mem_ar_addr_o,
  input  logic                             mem_r_valid_i,
  output logic                             mem_r_ready_o,
  input  dcache_pkg::beat_t                mem_r_data_i,
  output logic                             mem_aw_valid_o,
  input  logic                             mem_aw_ready_i,
  output dcache_pkg::addr_t                mem_aw_addr_o,
  output logic                             mem_w_valid_o,
  input  logic                             mem_w_ready_i,
  output dcache_pkg::beat_t                mem_w_data_o,
  input  logic                             mem_b_valid_i,
  output logic                             mem_b_ready_o,
  output dcache_pkg::addr_fields_t         lookup_o,
  output logic                             victim_way_o,
  input  logic                             hit_i,
  input  logic                             hit_way_i,
  input  logic                             victim_dirty_i,
  input  logic [`DC_TAG_W-1:0]             victim_tag_i,
  output dcache_pkg::tag_upd_t             tag_upd_o,
  output logic [`DC_INDEX_W-1:0]           rd_index_o,
  output dcache_pkg::data_wr_t             data_wr_o,
  input  dcache_pkg::line_t [`DC_WAYS-1:0] lines_i
);
  import dcache_pkg::*;

  dc_state_e             state_q;
  dc_state_e             state_n;
  cpu_req_t              req_q;
  cpu_rsp_t              rsp_q;
  logic                  ready_q;
  logic                  rsp_valid_q;
  logic                  vict_q;     // free-running victim pick
  logic [`DC_WAY_W-1:0]  way_q;
  logic [`DC_BEAT_W-1:0] beat_q;
  logic                  last_beat;

  assign last_beat   = (beat_q == (`DC_BEATS - 1));
  assign req_ready_o = ready_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  assign lookup_o     = req_q.addr;
  assign rd_index_o   = req_q.addr.index;
  assign victim_way_o = (state_q == st_lookup) ? vict_q : way_q;  // hold way after lookup

  assign mem_aw_valid_o = (state_q == st_wb_addr);
  assign mem_aw_addr_o  = {victim_tag_i, req_q.addr.index, {`DC_OFFSET_W{1'b0}}};
  assign mem_w_valid_o  = (state_q == st_wb_data);
  assign mem_w_data_o   = lines_i[way_q][beat_q];
  assign mem_b_ready_o  = (state_q == st_wb_resp);
  assign mem_ar_valid_o = (state_q == st_fill_addr);
  assign mem_ar_addr_o  = {req_q.addr.tag, req_q.addr.index, {`DC_OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == st_fill_data);

  always_comb begin
    state_n = state_q;
    case (state_q)
      st_idle:      if (req_valid_i && ready_q) state_n = st_lookup;
      st_lookup: begin
        if (hit_i) state_n = st_resp;
        else if (victim_dirty_i) state_n = st_wb_addr;
        else state_n = st_fill_addr;
      end
      st_resp:      if (rsp_valid_q && rsp_ready_i) state_n = st_idle;
      st_wb_addr:   if (mem_aw_ready_i) state_n = st_wb_data;
      st_wb_data:   if (mem_w_ready_i && last_beat) state_n = st_wb_resp;
      st_wb_resp:   if (mem_b_valid_i) state_n = st_fill_addr;
      st_fill_addr: if (mem_ar_ready_i) state_n = st_fill_data;
      st_fill_data: if (mem_r_valid_i && last_beat) state_n = st_lookup;  // retry as a hit
      default:      state_n = st_idle;
    endcase
  end

  // store updates, applied at the next edge
  always_comb begin
    tag_upd_o       = '0;
    data_wr_o       = '0;
    tag_upd_o.index = req_q.addr.index;
    tag_upd_o.tag   = req_q.addr.tag;
    tag_upd_o.valid = 1'b1;
    data_wr_o.index = req_q.addr.index;
    case (state_q)
      st_lookup: begin
        if (hit_i && req_q.write) begin
          tag_upd_o.en    = 1'b1;
          tag_upd_o.way   = hit_way_i;
          tag_upd_o.dirty = 1'b1;
          data_wr_o.en    = 1'b1;
          data_wr_o.way   = hit_way_i;
          data_wr_o.beat  = req_q.addr.offset[`DC_OFFSET_W-1];
          data_wr_o.data  = req_q.wdata;
          data_wr_o.strb  = req_q.strb;
        end
      end
      st_wb_resp: begin
        tag_upd_o.en  = mem_b_valid_i;  // victim now clean
        tag_upd_o.way = way_q;
        tag_upd_o.tag = victim_tag_i;
      end
      st_fill_data: begin
        data_wr_o.en   = mem_r_valid_i;
        data_wr_o.way  = way_q;
        data_wr_o.beat = beat_q;
        data_wr_o.data = mem_r_data_i;
        data_wr_o.strb = '1;
        tag_upd_o.en   = mem_r_valid_i && last_beat;
        tag_upd_o.way  = way_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= st_idle;
      ready_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      vict_q      <= 1'b0;
      way_q       <= '0;
      beat_q      <= '0;
    end else begin
      state_q <= state_n;
      ready_q <= (state_n == st_idle);
      vict_q  <= ~vict_q;
      if (state_q == st_lookup) way_q <= hit_i ? hit_way_i : vict_q;
      if (state_q == st_resp) begin
        if (!rsp_valid_q) rsp_valid_q <= 1'b1;  // lines valid this cycle
        else if (rsp_ready_i) rsp_valid_q <= 1'b0;
      end
      // wraps to zero after the last beat
      if ((state_q == st_wb_data && mem_w_ready_i) ||
          (state_q == st_fill_data && mem_r_valid_i)) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_idle && req_valid_i && ready_q) req_q <= req_i;
    if (state_q == st_resp && !rsp_valid_q) begin
      rsp_q.write <= req_q.write;
      rsp_q.rdata <= lines_i[way_q][req_q.addr.offset[`DC_OFFSET_W-1]];
    end
  end

  a_aw_hold : assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_addr_o));
  a_w_hold : assert property (@(posedge clk) disable iff (rst)
    mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o && $stable(mem_w_data_o));
  a_ar_hold : assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o));
  a_req_rsp_excl : assert property (@(posedge clk) disable iff (rst)
    !(req_ready_o && rsp_valid_o));

endmodule

/* dcache_top.sv */
// cpu side takes one request at a time; memory side beats are 64 bits, low beat first
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  dcache_pkg::cpu_req_t req_i,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output dcache_pkg::cpu_rsp_t rsp_o,
  output logic                 mem_ar_valid_o,
  input  logic                 mem_ar_ready_i,
  output dcache_pkg::addr_t    mem_ar_addr_o,
  input  logic                 mem_r_valid_i,
  output logic                 mem_r_ready_o,
  input  dcache_pkg::beat_t    mem_r_data_i,
  output logic                 mem_aw_valid_o,
  input  logic                 mem_aw_ready_i,
  output dcache_pkg::addr_t    mem_aw_addr_o,
  output logic                 mem_w_valid_o,
  input  logic                 mem_w_ready_i,
  output dcache_pkg::beat_t    mem_w_data_o,
  input  logic                 mem_b_valid_i,
  output logic                 mem_b_ready_o
);
  import dcache_pkg::*;

  addr_fields_t                lookup;
  logic                        victim_way;
  logic                        hit;
  logic                        hit_way;
  logic                        victim_dirty;
  logic [`DC_TAG_W-1:0]        victim_tag;
  tag_upd_t                    tag_upd;
  logic [`DC_INDEX_W-1:0]      rd_index;
  data_wr_t                    data_wr;
  line_t [`DC_WAYS-1:0]        lines;

  dcache_ctrl dcache_ctrl_inst (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_i          (req_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_o          (rsp_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i),
    .mem_aw_addr_o  (mem_aw_addr_o),
    .mem_w_valid_o  (mem_w_valid_o),
    .mem_w_ready_i  (mem_w_ready_i),
    .mem_w_data_o   (mem_w_data_o),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o),
    .lookup_o       (lookup),
    .victim_way_o   (victim_way),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .tag_upd_o      (tag_upd),
    .rd_index_o     (rd_index),
    .data_wr_o      (data_wr),
    .lines_i        (lines)
  );

  dcache_tag_store dcache_tag_store_inst (
    .clk            (clk),
    .rst            (rst),
    .lookup_i       (lookup),
    .victim_way_i   (victim_way),
    .upd_i          (tag_upd),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag)
  );

  dcache_data_store dcache_data_store_inst (
    .clk        (clk),
    .rd_index_i (rd_index),
    .wr_i       (data_wr),
    .lines_o    (lines)
  );

endmodule

/* tb_dcache.sv */
// memory model covers only the tag and set range picked below; expected data lives in a shadow
`timescale 1ns/10ps
`include "dcache_params.svh"

module tb_dcache;
  import dcache_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int N_RAND      = 400;
  localparam int N_REQ       = 16 + 512 + 8 + N_RAND;
  localparam int MISS_CYCLES = 100;  // generous bound for one access under random stalls
  localparam logic [17:0] ADDR_HI = 18'h2d68f;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic req_valid_i;
  logic req_ready_o;
  cpu_req_t req_i;
  logic rsp_valid_o;
  logic rsp_ready_i;
  cpu_rsp_t rsp_o;
  logic mem_ar_valid_o;
  logic mem_ar_ready_i;
  addr_t mem_ar_addr_o;
  logic mem_r_valid_i;
  logic mem_r_ready_o;
  beat_t mem_r_data_i;
  logic mem_aw_valid_o;
  logic mem_aw_ready_i;
  addr_t mem_aw_addr_o;
  logic mem_w_valid_o;
  logic mem_w_ready_i;
  beat_t mem_w_data_o;
  logic mem_b_valid_i;
  logic mem_b_ready_o;

  logic [`DC_DATA_W-1:0] mem_words [2048];  // indexed by addr[13:3]
  logic [`DC_DATA_W-1:0] shadow [2048];
  logic line_dirty [1024];
  logic [31:0] lfsr_q = 32'h9098_45d7;
  logic hit_expected = 1'b0;
  int n_checks = 0;
  int n_errors = 0;

  dcache_top dcache_top_inst (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] ref_merge(input logic [63:0] old, input logic [63:0] wdata,
                                            input logic [7:0] strb);
    logic [63:0] r;
    for (int b = 0; b < 8; b++) begin
      r[8*b +: 8] = strb[b] ? wdata[8*b +: 8] : old[8*b +: 8];
    end
    return r;
  endfunction

  function automatic logic [63:0] init_word(input logic [31:0] a);
    return {a ^ 32'h6b3d_91e5, ~a};
  endfunction

  function automatic logic [31:0] make_addr(input logic [1:0] tsel, input logic [1:0] ssel,
                                            input logic beat);
    return {ADDR_HI, 2'b00, tsel, ssel, 4'b0110, beat, 3'b000};
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // called on a rising edge, returns on the edge that takes the response
  task automatic access(input logic wr, input logic [31:0] addr, input logic [63:0] wdata,
                        input logic [7:0] strb, input logic hit_exp);
    #1;
    req_valid_i  = 1'b1;
    req_i        = {wr, addr, wdata, strb};
    hit_expected = hit_exp;
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
    #1 req_valid_i = 1'b0;
    @(posedge clk);
    while (!(rsp_valid_o && rsp_ready_i)) @(posedge clk);
  endtask

  // memory model, bookkeeping on the edge and new drive 1 ns later
  logic [31:0] rd_addr = '0;
  logic [31:0] wr_addr = '0;
  logic [1:0] rd_beat = '0;
  logic [1:0] wr_beat = '0;
  logic rd_active = 1'b0;
  logic b_pend = 1'b0;
  logic r_hold;
  logic b_hold;
  always @(posedge clk) begin
    r_hold = mem_r_valid_i && !mem_r_ready_o;
    b_hold = mem_b_valid_i && !mem_b_ready_o;
    if (!rst) begin
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        rd_addr   = mem_ar_addr_o;
        rd_beat   = '0;
        rd_active = 1'b1;
      end
      if (mem_r_valid_i && mem_r_ready_o) begin
        rd_beat++;
        if (rd_beat == 2) rd_active = 1'b0;
      end
      if (mem_aw_valid_o && mem_aw_ready_i) begin
        wr_addr = mem_aw_addr_o;
        wr_beat = '0;
      end
      if (mem_w_valid_o && mem_w_ready_i) begin
        mem_words[{wr_addr[13:4], wr_beat[0]}] = mem_w_data_o;
        wr_beat++;
        if (wr_beat == 2) b_pend = 1'b1;
      end
      if (mem_b_valid_i && mem_b_ready_o) b_pend = 1'b0;
    end
    #1;
    mem_ar_ready_i = rand_bits(1);
    mem_aw_ready_i = rand_bits(1);
    mem_w_ready_i  = rand_bits(1);
    mem_r_valid_i  = rd_active && (r_hold || rand_bits(1));
    mem_r_data_i   = mem_words[{rd_addr[13:4], rd_beat[0]}];
    mem_b_valid_i  = b_pend && (b_hold || rand_bits(1));
    rsp_ready_i    = |rand_bits(2);  // stalls about a quarter of the time
  end

  // compare process
  int cyc = 0;
  int acc_cyc = 0;
  logic req_seen = 1'b0;
  logic miss_seen = 1'b0;
  logic rsp_seen = 1'b0;
  logic rsp_hold = 1'b0;
  logic cur_hit_exp = 1'b0;
  cpu_req_t cur_req;
  cpu_rsp_t rsp_prev;
  logic [31:0] cur_addr;
  logic [31:0] wb_addr;
  logic [63:0] exp_rdata;
  logic wb_beat;
  always @(posedge clk) begin
    if (rst) begin
      if (cyc > 0) begin
        check("reset outputs", {req_ready_o, rsp_valid_o, mem_ar_valid_o, mem_aw_valid_o,
                                mem_w_valid_o, mem_r_ready_o, mem_b_ready_o}, '0);
      end
    end else begin
      if (!req_seen) check("mem valids before first request",
                           {mem_ar_valid_o, mem_aw_valid_o, mem_w_valid_o}, '0);
      if (req_valid_i && req_ready_o) begin
        req_seen    = 1'b1;
        cur_req     = req_i;
        cur_addr    = req_i.addr;
        cur_hit_exp = hit_expected;
        acc_cyc     = cyc;
        miss_seen   = 1'b0;
        rsp_seen    = 1'b0;
        if (req_i.write) begin
          shadow[cur_addr[13:3]] = ref_merge(shadow[cur_addr[13:3]], req_i.wdata, req_i.strb);
          line_dirty[cur_addr[13:4]] = 1'b1;
        end else begin
          exp_rdata = shadow[cur_addr[13:3]];
        end
      end
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        miss_seen = 1'b1;
        check("mem_ar_addr_o", mem_ar_addr_o, {cur_addr[31:4], 4'h0});
      end
      if (mem_aw_valid_o && mem_aw_ready_i) begin
        miss_seen = 1'b1;
        wb_addr   = mem_aw_addr_o;
        wb_beat   = 1'b0;
        check("mem_aw_addr_o", {wb_addr[31:14], wb_addr[3:0]}, {ADDR_HI, 4'h0});
        check("write-back of a clean line", !line_dirty[wb_addr[13:4]], 1'b0);
        line_dirty[wb_addr[13:4]] = 1'b0;
      end
      if (mem_w_valid_o && mem_w_ready_i) begin
        check("mem_w_data_o", mem_w_data_o, shadow[{wb_addr[13:4], wb_beat}]);
        wb_beat = ~wb_beat;
      end
      if (rsp_valid_o && !rsp_seen) begin
        rsp_seen = 1'b1;
        if (!miss_seen) check("hit latency", cyc - acc_cyc - 1, 2);
        if (cur_hit_exp) check("memory traffic on repeat access", miss_seen, 1'b0);
      end
      if (rsp_hold) begin
        check("rsp_valid_o", rsp_valid_o, 1'b1);
        check("rsp_o", rsp_o, rsp_prev);
      end
      if (rsp_valid_o && rsp_ready_i) begin
        check("rsp_o.write", rsp_o.write, cur_req.write);
        if (!cur_req.write) check("rsp_o.rdata", rsp_o.rdata, exp_rdata);
      end
      rsp_hold = rsp_valid_o && !rsp_ready_i;
      rsp_prev = rsp_o;
    end
    cyc++;
  end

  initial begin
    logic wr;
    logic [1:0] tsel;
    logic [1:0] ssel;
    logic beat;
    logic [7:0] strb;
    logic [63:0] wdata;
    req_valid_i    = 1'b0;
    req_i          = '0;
    rsp_ready_i    = 1'b0;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_aw_ready_i = 1'b0;
    mem_w_ready_i  = 1'b0;
    mem_b_valid_i  = 1'b0;
    for (int i = 0; i < 2048; i++) begin
      mem_words[i] = init_word({ADDR_HI, i[10:0], 3'b000});
      shadow[i]    = mem_words[i];
    end
    for (int i = 0; i < 1024; i++) line_dirty[i] = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
    // cold reads, then repeats on the same line
    for (int s = 0; s < 4; s++) begin
      access(1'b0, make_addr(s, s, 1'b0), '0, '0, 1'b0);
      access(1'b0, make_addr(s, s, 1'b1), '0, '0, 1'b1);
      access(1'b1, make_addr(s, s, 1'b1), rand_bits(64), 8'h3c, 1'b1);
      access(1'b0, make_addr(s, s, 1'b1), '0, '0, 1'b1);
    end
    for (int p = 0; p < 256; p++) begin
      access(1'b1, make_addr(2'd1, 2'd2, p[0]), rand_bits(64), p[7:0], p != 0);
      access(1'b0, make_addr(2'd1, 2'd2, p[0]), '0, '0, 1'b1);
    end
    // four tags into one set of two ways
    for (int t = 0; t < 4; t++) access(1'b1, make_addr(t, 2'd3, t[0]), rand_bits(64), 8'hff, 1'b0);
    for (int t = 0; t < 4; t++) access(1'b0, make_addr(t, 2'd3, t[0]), '0, '0, 1'b0);
    for (int i = 0; i < N_RAND; i++) begin
      wr    = rand_bits(1);
      tsel  = rand_bits(2);
      ssel  = rand_bits(2);
      beat  = rand_bits(1);
      strb  = rand_bits(8);
      wdata = rand_bits(64);
      access(wr, make_addr(tsel, ssel, beat), wdata, strb, 1'b0);
    end
    repeat (4) @(posedge clk);
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(N_REQ * MISS_CYCLES * CLK_PERIOD);
    $display("timeout after %0d requests worth of cycles, the run hung", N_REQ);
    $display("checks %0d errors %0d", n_checks, n_errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* all.f */
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv
